// ==== compile.f ====
cpu_pkg.sv
mem_if.sv
cpu_alu.sv
gpr_file.sv
mem_port.sv
cpu_seq.sv
cpu_top.sv
tb_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_cpu \
    -f compile.f -o tb_cpu_sim \
    && { ./obj_dir/tb_cpu_sim > sim.log 2>&1; cat sim.log; }
grep -q "^Testbench passed$" sim.log \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }

// ==== tb_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int          store_timeout = 2000;   // Cycles per awaited store.
    localparam logic [31:0] lfsr_seed     = 32'h98d9_a6b8;

    logic                 clk;
    logic                 rst;
    logic [mem_w-1:0]     ram_din;
    logic                 ram_ready;
    logic [mem_w-1:0]     ram_dout;
    logic [7:0]           ram_mask;
    logic [dw_addr_w-1:0] ram_addr;
    logic                 ram_we;
    logic                 ram_re;

    logic [63:0]          mem [256];      // Doubleword memory model.
    logic [9:0]           hw_pos;         // Next program halfword.
    logic [31:0]          lfsr;
    logic                 rand_ready;
    logic                 seen_we;
    logic [dw_addr_w-1:0] we_addr;
    logic [7:0]           we_mask;
    logic [63:0]          we_data;

    cpu_top dut (
        .clk         (clk),
        .rst         (rst),
        .ram_din_i   (ram_din),
        .ram_ready_i (ram_ready),
        .ram_dout_o  (ram_dout),
        .ram_mask_o  (ram_mask),
        .ram_addr_o  (ram_addr),
        .ram_we_o    (ram_we),
        .ram_re_o    (ram_re)
    );

    assign ram_din = mem[ram_addr[7:0]];  // Memory answers combinationally.

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] fill_pattern(input logic [7:0] a);
        return {a, 8'h3C, ~a, 8'hA5, a ^ 8'h5A, 8'h96, ~a ^ 8'h33, 8'h69};
    endfunction

    // Expected CC of an add, from the signed sum at full precision.
    function automatic logic [1:0] add_cc(input logic [31:0] a, input logic [31:0] b);
        longint s;
        s = longint'($signed(a)) + longint'($signed(b));
        if (s > 64'sd2147483647 || s < -64'sd2147483648) begin
            return 2'd3;
        end else if (s == 0) begin
            return 2'd0;
        end else if (s < 0) begin
            return 2'd1;
        end
        return 2'd2;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic drive_ready();
        if (rand_ready) begin
            lfsr      = lfsr_next(lfsr);
            ram_ready = lfsr[0];
        end else begin
            ram_ready = 1'b1;
        end
    endtask

    task automatic fill_memory();
        logic [8:0] i;
        for (i = 9'd0; i < 9'd256; i++) begin
            mem[i[7:0]] = fill_pattern(i[7:0]);
        end
        hw_pos = '0;
    endtask

    task automatic put_hw(input logic [15:0] hw);
        logic [5:0] sh;
        sh = {hw_pos[1:0] ^ 2'b11, 4'b0000};   // Offset 0 sits in bits 63:48.
        mem[hw_pos[9:2]] = (mem[hw_pos[9:2]] & ~(64'hFFFF << sh)) | ({48'd0, hw} << sh);
        hw_pos++;
    endtask

    task automatic put_rr(input logic [7:0] op, input logic [3:0] r1, input logic [3:0] r2);
        put_hw({op, r1, r2});
    endtask

    task automatic put_rx(input logic [7:0] op, input logic [3:0] r1, input logic [3:0] x2,
                          input logic [3:0] b2, input logic [11:0] disp);
        put_hw({op, r1, x2});
        put_hw({b2, disp});
    endtask

    task automatic poke_word(input logic [30:0] byte_addr, input logic [31:0] word);
        if (byte_addr[2]) begin
            mem[byte_addr[10:3]][31:0] = word;
        end else begin
            mem[byte_addr[10:3]][63:32] = word;
        end
    endtask

    // Memory is refilled once the core sits in reset.
    task automatic hold_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        fill_memory();
    endtask

    task automatic release_reset();
        rst = 1'b0;
        drive_ready();
    endtask

    task automatic next_cycle();
        logic wr_now;
        logic [63:0] merged;
        int k;
        @(posedge clk);
        assert (ram_ready || !(ram_we || ram_re))
            else fail_run("A memory strobe was raised while ready was low.");
        wr_now = ram_we;
        if (ram_we) begin
            seen_we = 1'b1;
            we_addr = ram_addr;
            we_mask = ram_mask;
            we_data = ram_dout;
        end
        @(negedge clk);
        if (wr_now) begin
            merged = mem[we_addr[7:0]];
            for (k = 0; k < 8; k++) begin
                if (we_mask[k]) merged[8*k +: 8] = we_data[8*k +: 8];
            end
            mem[we_addr[7:0]] = merged;
        end
        drive_ready();
    endtask

    task automatic expect_store(input logic [30:0] byte_addr, input logic [31:0] word);
        logic [63:0] exp_dout;
        logic [7:0]  exp_mask;
        int          waited;
        exp_mask = byte_addr[2] ? 8'h0F : 8'hF0;
        exp_dout = byte_addr[2] ? {32'd0, word} : {word, 32'd0};
        seen_we  = 1'b0;
        waited   = 0;
        while (!seen_we && waited < store_timeout) begin
            next_cycle();
            waited++;
        end
        assert (seen_we)
            else fail_run($sformatf("The store to byte address %h never came.", byte_addr));
        assert (we_addr == byte_addr[30:3])
            else report_mismatch("ram_addr_o", 64'(we_addr), 64'(byte_addr[30:3]));
        assert (we_mask == exp_mask)
            else report_mismatch("ram_mask_o", 64'(we_mask), 64'(exp_mask));
        assert (we_data == exp_dout) else report_mismatch("ram_dout_o", we_data, exp_dout);
    endtask

    task automatic load_store_test(input logic [31:0] value);
        hold_reset();
        put_rx(op_l, 4'd2, 4'd0, 4'd0, 12'h100);    // Base 40h.
        put_rx(op_l, 4'd3, 4'd0, 4'd0, 12'h104);    // Index 80h.
        put_rx(op_l, 4'd4, 4'd2, 4'd3, 12'h104);    // Reads 1C4h.
        put_rx(op_st, 4'd4, 4'd0, 4'd2, 12'h1C0);   // Upper lane at 200h.
        put_rx(op_st, 4'd4, 4'd3, 4'd0, 12'h18C);   // Lower lane at 20Ch.
        poke_word(31'h100, 32'h0000_0040);
        poke_word(31'h104, 32'h0000_0080);
        poke_word(31'h1C4, value);
        release_reset();
        expect_store(31'h200, value);
        expect_store(31'h20C, value);
    endtask

    task automatic rr_test(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] expected);
        hold_reset();
        put_rx(op_l, 4'd5, 4'd0, 4'd0, 12'h108);
        put_rx(op_l, 4'd6, 4'd0, 4'd0, 12'h10C);
        put_rr(op, 4'd5, 4'd6);
        put_rx(op_st, 4'd5, 4'd0, 4'd0, 12'h200);
        poke_word(31'h108, a);
        poke_word(31'h10C, b);
        release_reset();
        expect_store(31'h200, expected);
    endtask

    // Target store at byte 20, fall-through store at byte 16.
    task automatic bcr_test(input logic [31:0] a, input logic [31:0] b, input logic [3:0] mask,
                            input logic taken);
        hold_reset();
        put_rx(op_l, 4'd5, 4'd0, 4'd0, 12'h108);
        put_rx(op_l, 4'd6, 4'd0, 4'd0, 12'h10C);
        put_rx(op_l, 4'd10, 4'd0, 4'd0, 12'h110);
        put_rr(op_ar, 4'd5, 4'd6);
        put_rr(op_bcr, mask, 4'd10);
        put_rx(op_st, 4'd6, 4'd0, 4'd0, 12'h208);
        put_rx(op_st, 4'd6, 4'd0, 4'd0, 12'h200);
        poke_word(31'h108, a);
        poke_word(31'h10C, b);
        poke_word(31'h110, 32'd20);
        release_reset();
        expect_store(taken ? 31'h200 : 31'h208, b);
    endtask

    task automatic cc_case(input logic [31:0] a, input logic [31:0] b);
        logic [3:0] hit;
        hit = 4'b1000 >> add_cc(a, b);              // Mask bit 8 is CC 0.
        bcr_test(a, b, hit, 1'b1);
        bcr_test(a, b, ~hit, 1'b0);
    endtask

    task automatic run_basic_tests();
        logic [31:0] x;
        logic [31:0] y;
        x = 32'hC3A5_1E69;
        y = 32'h5F0F_A0F3;
        load_store_test(x);
        rr_test(op_ar, 32'h1234_5678, 32'h8765_4321, 32'h1234_5678 + 32'h8765_4321);
        rr_test(op_sr, 32'h0000_0010, 32'h0000_0025, 32'h0000_0010 - 32'h0000_0025);
        rr_test(op_nr, x, y, x & y);
        rr_test(op_or, x, y, x | y);
        rr_test(op_xr, x, y, x ^ y);
        rr_test(op_lr, x, y, y);
    endtask

    initial begin
        rst        = 1'b1;
        ram_ready  = 1'b1;
        rand_ready = 1'b0;
        lfsr       = lfsr_seed;
        seen_we    = 1'b0;
        we_addr    = '0;
        we_mask    = '0;
        we_data    = '0;
        fill_memory();
        run_basic_tests();
        cc_case(32'h7FFF_FFFF, 32'h0000_0001);     // Positive overflow.
        cc_case(32'h8000_0000, 32'hFFFF_FFFF);     // Negative overflow.
        cc_case(32'h0000_0005, 32'hFFFF_FFFB);
        cc_case(32'h0000_0001, 32'hFFFF_FFF0);
        cc_case(32'h0000_0003, 32'h0000_0004);
        rand_ready = 1'b1;
        run_basic_tests();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [mem_w-1:0]      ram_din_i,
    input  wire                  ram_ready_i,
    output logic [mem_w-1:0]     ram_dout_o,
    output logic [7:0]           ram_mask_o,
    output logic [dw_addr_w-1:0] ram_addr_o,
    output logic                 ram_we_o,
    output logic                 ram_re_o
);

    logic [reg_idx_w-1:0] idx_a;
    logic [reg_idx_w-1:0] idx_b;
    logic [xlen-1:0]      rd_a;
    logic [xlen-1:0]      rd_b;
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_idx;
    logic [xlen-1:0]      wr_data;
    alu_op_t              alu_op;
    logic [xlen-1:0]      alu_res;
    cc_t                  alu_cc;
    logic                 alu_cc_valid;

    mem_if mem_bus ();

    cpu_seq u_seq (
        .clk            (clk),
        .rst            (rst),
        .rd_a_i         (rd_a),
        .rd_b_i         (rd_b),
        .alu_res_i      (alu_res),
        .alu_cc_i       (alu_cc),
        .alu_cc_valid_i (alu_cc_valid),
        .idx_a_o        (idx_a),
        .idx_b_o        (idx_b),
        .wr_en_o        (wr_en),
        .wr_idx_o       (wr_idx),
        .wr_data_o      (wr_data),
        .alu_op_o       (alu_op),
        .mem            (mem_bus.seq)
    );

    gpr_file u_gpr (
        .clk       (clk),
        .rst       (rst),
        .idx_a_i   (idx_a),
        .idx_b_i   (idx_b),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data),
        .rd_a_o    (rd_a),
        .rd_b_o    (rd_b)
    );

    cpu_alu u_alu (
        .op_i       (alu_op),
        .a_i        (rd_a),
        .b_i        (rd_b),
        .res_o      (alu_res),
        .cc_o       (alu_cc),
        .cc_valid_o (alu_cc_valid)
    );

    mem_port u_mem (
        .ram_din_i   (ram_din_i),
        .ram_ready_i (ram_ready_i),
        .ram_dout_o  (ram_dout_o),
        .ram_mask_o  (ram_mask_o),
        .ram_addr_o  (ram_addr_o),
        .ram_we_o    (ram_we_o),
        .ram_re_o    (ram_re_o),
        .mem         (mem_bus.port)
    );

endmodule

`default_nettype wire

// ==== cpu_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_seq import cpu_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [xlen-1:0]       rd_a_i,
    input  wire [xlen-1:0]       rd_b_i,
    input  wire [xlen-1:0]       alu_res_i,
    input  wire cc_t             alu_cc_i,
    input  wire                  alu_cc_valid_i,
    output logic [reg_idx_w-1:0] idx_a_o,
    output logic [reg_idx_w-1:0] idx_b_o,
    output logic                 wr_en_o,
    output logic [reg_idx_w-1:0] wr_idx_o,
    output logic [xlen-1:0]      wr_data_o,
    output alu_op_t              alu_op_o,
    mem_if.seq                   mem
);

    cpu_state_t             state;
    cpu_state_t             state_nxt;
    logic [addr_w-1:0]      pc;
    logic [31:0]            ir;         // First halfword in the upper half.
    cc_t                    cc;
    logic [xlen-1:0]        st_data;    // Store operand, read during fetch2.

    logic [7:0]             opcode;
    logic [reg_idx_w-1:0]   r1;
    logic [reg_idx_w-1:0]   r2;
    logic [reg_idx_w-1:0]   x2;
    logic [reg_idx_w-1:0]   b2;
    logic [11:0]            disp;
    logic                   rx_state;
    logic                   rr_wr;
    logic                   bcr_taken;
    logic [xlen-1:0]        ea_x;
    logic [xlen-1:0]        ea_b;
    logic [xlen-1:0]        ea;

    assign opcode = ir[31:24];
    assign r1     = ir[23:20];         // Also the BCR mask.
    assign r2     = ir[19:16];
    assign x2     = ir[19:16];         // Same field as r2 in RX format.
    assign b2     = ir[15:12];
    assign disp   = ir[11:0];

    assign rx_state = (state == st_load_rx) || (state == st_save_rx);

    // RX states read index and base; otherwise r1 and r2.
    assign idx_a_o = rx_state ? x2 : r1;
    assign idx_b_o = rx_state ? b2 : r2;

    // Register 0 contributes nothing to the address.
    assign ea_x = (x2 != '0) ? rd_a_i : '0;
    assign ea_b = (b2 != '0) ? rd_b_i : '0;
    assign ea   = xlen'(disp) + ea_x + ea_b;

    always_comb begin
        alu_op_o = alu_pass;
        rr_wr    = 1'b0;
        case (opcode)
            op_lr: begin
                alu_op_o = alu_pass;
                rr_wr    = 1'b1;
            end
            op_ar: begin
                alu_op_o = alu_add;
                rr_wr    = 1'b1;
            end
            op_sr: begin
                alu_op_o = alu_sub;
                rr_wr    = 1'b1;
            end
            op_nr: begin
                alu_op_o = alu_and;
                rr_wr    = 1'b1;
            end
            op_or: begin
                alu_op_o = alu_or;
                rr_wr    = 1'b1;
            end
            op_xr: begin
                alu_op_o = alu_xor;
                rr_wr    = 1'b1;
            end
            default: begin
                alu_op_o = alu_pass;                // BCR and unknown opcodes.
                rr_wr    = 1'b0;
            end
        endcase
    end

    // Mask bit 3 - cc, which is the inverted CC.
    assign bcr_taken = (opcode == op_bcr) && r1[~cc] && (r2 != '0);

    assign wr_en_o   = ((state == st_exec_rr) && rr_wr) ||
                       ((state == st_load_rx) && mem.ready);
    assign wr_idx_o  = r1;
    assign wr_data_o = (state == st_load_rx) ? mem.rd_word : alu_res_i;

    assign mem.rd_req    = (state == st_fetch1) || (state == st_fetch2) ||
                           (state == st_load_rx);
    assign mem.wr_req    = (state == st_save_rx);
    assign mem.byte_addr = rx_state ? ea[addr_w-1:0] : pc;
    assign mem.wdata     = st_data;

    always_comb begin
        state_nxt = state;
        case (state)
            st_init:    state_nxt = st_fetch1;
            st_fetch1: begin
                if (mem.ready) begin
                    // Format comes from the halfword on the bus.
                    state_nxt = (mem.rd_hw[15:14] == op_rr_fmt) ? st_exec_rr : st_fetch2;
                end
            end
            st_fetch2: begin
                if (mem.ready) begin
                    if (opcode == op_l) begin
                        state_nxt = st_load_rx;
                    end else if (opcode == op_st) begin
                        state_nxt = st_save_rx;
                    end else begin
                        state_nxt = st_fetch1;      // Unknown RX is a no-op.
                    end
                end
            end
            st_exec_rr: state_nxt = st_fetch1;
            st_load_rx: state_nxt = mem.ready ? st_fetch1 : st_load_rx;
            st_save_rx: state_nxt = mem.ready ? st_fetch1 : st_save_rx;
            default:    state_nxt = st_init;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_init;
            pc    <= '0;
            ir    <= '0;
            cc    <= '0;
        end else begin
            state <= state_nxt;
            if (mem.ready && ((state == st_fetch1) || (state == st_fetch2))) begin
                pc <= pc + addr_w'(2);
            end else if ((state == st_exec_rr) && bcr_taken) begin
                pc <= {rd_b_i[addr_w-1:1], 1'b0};
            end
            if (mem.ready && (state == st_fetch1)) begin
                ir[31:16] <= mem.rd_hw;
            end
            if (mem.ready && (state == st_fetch2)) begin
                ir[15:0] <= mem.rd_hw;
            end
            if ((state == st_exec_rr) && alu_cc_valid_i) begin
                cc <= alu_cc_i;
            end
        end
    end

    // Port A reads r1 during fetch2, ahead of the address phase.
    always_ff @(posedge clk) begin
        if ((state == st_fetch2) && mem.ready) begin
            st_data <= rd_a_i;
        end
    end

endmodule

`default_nettype wire

// ==== mem_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_port import cpu_pkg::*; (
    input  wire [mem_w-1:0]      ram_din_i,
    input  wire                  ram_ready_i,
    output logic [mem_w-1:0]     ram_dout_o,
    output logic [7:0]           ram_mask_o,
    output logic [dw_addr_w-1:0] ram_addr_o,
    output logic                 ram_we_o,
    output logic                 ram_re_o,
    mem_if.port                  mem
);

    logic lower_word;                   // Offset 4 within the doubleword.

    assign lower_word = mem.byte_addr[2];

    assign ram_addr_o = mem.byte_addr[addr_w-1:3];
    assign ram_re_o   = mem.rd_req & ram_ready_i;
    assign ram_we_o   = mem.wr_req & ram_ready_i;
    assign mem.ready  = ram_ready_i;

    // Big-endian, so offset 0 sits in the top bits.
    always_comb begin
        case (mem.byte_addr[2:1])
            2'd0:    mem.rd_hw = ram_din_i[63:48];
            2'd1:    mem.rd_hw = ram_din_i[47:32];
            2'd2:    mem.rd_hw = ram_din_i[31:16];
            default: mem.rd_hw = ram_din_i[15:0];
        endcase
    end

    assign mem.rd_word = lower_word ? ram_din_i[31:0] : ram_din_i[63:32];

    // Store data goes in one word lane, the other lane is zero.
    always_comb begin
        if (lower_word) begin
            ram_dout_o = {{(mem_w - xlen){1'b0}}, mem.wdata};
            ram_mask_o = 8'h0F;
        end else begin
            ram_dout_o = {mem.wdata, {(mem_w - xlen){1'b0}}};
            ram_mask_o = 8'hF0;
        end
    end

endmodule

`default_nettype wire

// ==== gpr_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpr_file import cpu_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [reg_idx_w-1:0]  idx_a_i,
    input  wire [reg_idx_w-1:0]  idx_b_i,
    input  wire                  wr_en_i,
    input  wire [reg_idx_w-1:0]  wr_idx_i,
    input  wire [xlen-1:0]       wr_data_i,
    output logic [xlen-1:0]      rd_a_o,
    output logic [xlen-1:0]      rd_b_o
);

    logic [xlen-1:0] regs [2**reg_idx_w];

    assign rd_a_o = regs[idx_a_i];      // Combinational reads.
    assign rd_b_o = regs[idx_b_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_idx_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  wire alu_op_t         op_i,
    input  wire [xlen-1:0]       a_i,
    input  wire [xlen-1:0]       b_i,
    output logic [xlen-1:0]      res_o,
    output cc_t                  cc_o,
    output logic                 cc_valid_o
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic            add_ovf;
    logic            sub_ovf;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;

    // Signed overflow from the operand and result sign bits.
    assign add_ovf = (a_i[xlen-1] == b_i[xlen-1]) && (sum[xlen-1] != a_i[xlen-1]);
    assign sub_ovf = (a_i[xlen-1] != b_i[xlen-1]) && (diff[xlen-1] != a_i[xlen-1]);

    always_comb begin
        res_o      = b_i;
        cc_o       = 2'd0;
        cc_valid_o = 1'b1;
        case (op_i)
            alu_add, alu_sub: begin
                res_o = (op_i == alu_add) ? sum : diff;
                if ((op_i == alu_add) ? add_ovf : sub_ovf) begin
                    cc_o = 2'd3;
                end else if (res_o == '0) begin
                    cc_o = 2'd0;
                end else if (res_o[xlen-1]) begin
                    cc_o = 2'd1;                    // Negative.
                end else begin
                    cc_o = 2'd2;                    // Positive.
                end
            end
            alu_and, alu_or, alu_xor: begin
                if (op_i == alu_and) begin
                    res_o = a_i & b_i;
                end else if (op_i == alu_or) begin
                    res_o = a_i | b_i;
                end else begin
                    res_o = a_i ^ b_i;
                end
                cc_o = (res_o == '0) ? 2'd0 : 2'd1;
            end
            default: begin
                res_o      = b_i;                   // Copy for LR.
                cc_valid_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== mem_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mem_if import cpu_pkg::*; ();

    logic              rd_req;     // Fetch or load pending.
    logic              wr_req;     // Store pending.
    logic [addr_w-1:0] byte_addr;
    logic [xlen-1:0]   wdata;
    logic              ready;
    logic [15:0]       rd_hw;      // Halfword at byte_addr.
    logic [xlen-1:0]   rd_word;    // Word at byte_addr.

    modport seq (
        output rd_req, wr_req, byte_addr, wdata,
        input  ready, rd_hw, rd_word
    );

    modport port (
        input  rd_req, wr_req, byte_addr, wdata,
        output ready, rd_hw, rd_word
    );

endinterface

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int unsigned xlen      = 32;             // GPR and ALU width.
    localparam int unsigned mem_w     = 64;             // Memory data width.
    localparam int unsigned addr_w    = 31;             // Byte address width.
    localparam int unsigned dw_addr_w = addr_w - 3;     // Doubleword address.
    localparam int unsigned reg_idx_w = 4;              // Register index width.

    // RR opcodes, one halfword.
    localparam logic [7:0] op_bcr = 8'h07;              // Branch on condition.
    localparam logic [7:0] op_nr  = 8'h14;
    localparam logic [7:0] op_or  = 8'h16;
    localparam logic [7:0] op_xr  = 8'h17;
    localparam logic [7:0] op_lr  = 8'h18;
    localparam logic [7:0] op_ar  = 8'h1A;
    localparam logic [7:0] op_sr  = 8'h1B;

    // RX opcodes, two halfwords.
    localparam logic [7:0] op_st  = 8'h50;              // Store word.
    localparam logic [7:0] op_l   = 8'h58;              // Load word.

    localparam logic [1:0] op_rr_fmt = 2'b00;           // Top opcode bits of RR.

    typedef enum logic [2:0] {
        st_init,
        st_fetch1,
        st_fetch2,
        st_exec_rr,
        st_load_rx,
        st_save_rx
    } cpu_state_t;

    typedef enum logic [2:0] {
        alu_pass,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    typedef logic [1:0] cc_t;

endpackage

`default_nettype wire
